//--- tb/snoop_arb_vectors.txt
# name req addr snoop prot permit stall snq_empty ctcq_empty cr_acept snq_crv ctcq_crv ctcq_2_cmplt
# then expected: ready snp_create ctc_create ctc_type asid_va 2nd_trans va_pa snq_oldest ctcq_oldest
rst_idle   0 0000000000 0 0 1 0 1 1 0 0 0 0  0 0 0 00 000000 0 000000000 00 00
snp_stall  1 123456789a 5 3 1 1 1 1 0 0 0 0  0 0 0 38 123456 0 123456789 00 00
snp_noperm 1 123456789a 5 3 0 0 1 1 0 0 0 0  0 0 0 38 123456 0 123456789 00 00
snp_full   1 123456789a 5 3 1 0 0 1 0 0 0 0  0 0 0 38 123456 0 123456789 00 00
ctc_full   1 abcdef5041 f 0 1 0 1 0 0 0 0 0  0 0 0 2d abcdef 1 abcdef504 00 00
ord_snp1   1 123456789a 5 3 1 0 1 1 0 0 0 0  1 1 0 38 123456 0 123456789 00 00
ord_ctc1   1 abcdef5041 f 0 1 0 0 1 0 0 0 0  1 0 1 2d abcdef 1 abcdef504 01 00
ord_snp2   1 123456789a 5 3 1 0 1 1 0 0 0 0  1 1 0 38 123456 0 123456789 01 00
ord_rsp1   0 0000000000 0 0 1 0 1 1 1 1 0 0  0 0 0 00 000000 0 000000000 01 00
ord_rsp2   0 0000000000 0 0 1 0 1 1 1 0 1 0  0 0 0 00 000000 0 000000000 00 01
ord_rsp3   0 0000000000 0 0 1 0 1 1 1 1 0 0  0 0 0 00 000000 0 000000000 02 00
ord_empty  0 0000000000 0 0 1 0 1 1 0 0 0 0  0 0 0 00 000000 0 000000000 00 00
two_ctc1   1 abcdef5041 f 0 1 0 1 1 0 0 0 0  1 0 1 2d abcdef 1 abcdef504 00 00
two_ctc2   1 0fedcba980 f 0 1 0 1 1 0 0 0 0  1 0 1 10 0fedcb 0 0fedcba98 00 02
two_rsp1   0 0000000000 0 0 1 0 1 1 1 0 1 1  0 0 0 00 000000 0 000000000 00 02
two_rsp2   0 0000000000 0 0 1 0 1 1 1 0 1 0  0 0 0 00 000000 0 000000000 00 02
two_empty  0 0000000000 0 0 1 0 1 1 0 0 0 0  0 0 0 00 000000 0 000000000 00 00
wrap_01    1 0000000000 0 0 1 0 1 1 0 0 0 0  1 1 0 00 000000 0 000000000 00 00
wrap_02    1 0000000000 0 0 1 0 1 1 1 1 0 0  1 1 0 00 000000 0 000000000 04 00
wrap_03    1 0000000000 0 0 1 0 1 1 1 1 0 0  1 1 0 00 000000 0 000000000 08 00
wrap_04    1 0000000000 0 0 1 0 1 1 1 1 0 0  1 1 0 00 000000 0 000000000 10 00
wrap_05    1 0000000000 0 0 1 0 1 1 1 1 0 0  1 1 0 00 000000 0 000000000 20 00
wrap_06    1 0000000000 0 0 1 0 1 1 1 1 0 0  1 1 0 00 000000 0 000000000 01 00
wrap_07    1 0000000000 0 0 1 0 1 1 1 1 0 0  1 1 0 00 000000 0 000000000 02 00
wrap_08    1 0000000000 0 0 1 0 1 1 1 1 0 0  1 1 0 00 000000 0 000000000 04 00
wrap_09    1 0000000000 0 0 1 0 1 1 1 1 0 0  1 1 0 00 000000 0 000000000 08 00
wrap_10    1 0000000000 0 0 1 0 1 1 1 1 0 0  1 1 0 00 000000 0 000000000 10 00
wrap_11    1 0000000000 0 0 1 0 1 1 1 1 0 0  1 1 0 00 000000 0 000000000 20 00
wrap_12    1 0000000000 0 0 1 0 1 1 1 1 0 0  1 1 0 00 000000 0 000000000 01 00
wrap_13    1 0000000000 0 0 1 0 1 1 1 1 0 0  1 1 0 00 000000 0 000000000 02 00
wrap_14    1 0000000000 f 0 1 0 1 1 1 1 0 0  1 0 1 00 000000 0 000000000 04 00
wrap_15    1 0000000000 0 0 1 0 1 1 1 0 1 0  1 1 0 00 000000 0 000000000 00 04
wrap_16    1 0000000000 0 0 1 0 1 1 1 1 0 0  1 1 0 00 000000 0 000000000 08 00
wrap_17    1 0000000000 0 0 1 0 1 1 1 1 0 0  1 1 0 00 000000 0 000000000 10 00
wrap_18    1 0000000000 0 0 1 0 1 1 1 1 0 0  1 1 0 00 000000 0 000000000 20 00
wrap_19    1 0000000000 0 0 1 0 1 1 1 1 0 0  1 1 0 00 000000 0 000000000 01 00
wrap_20    0 0000000000 0 0 1 0 1 1 1 1 0 0  0 0 0 00 000000 0 000000000 02 00
wrap_21    0 0000000000 0 0 1 0 1 1 0 0 0 0  0 0 0 00 000000 0 000000000 00 00

//--- build.f
source/snoop_arb_pkg.sv
source/coq_write_if.sv
source/ac_classify.sv
source/coq_alloc.sv
source/coq_entry.sv
source/resp_order_select.sv
source/snoop_req_arbiter.sv
tb/snoop_arb_checker.sv
tb/tb_snoop_req_arbiter.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run from the project root, pass only if the run reports it
verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_snoop_req_arbiter -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "TEST PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- tb/tb_snoop_req_arbiter.sv
`timescale 1ns/1ps

module tb_snoop_req_arbiter
  import snoop_arb_pkg::*;
();

  localparam int coq_depth = 18;
  localparam int idx_depth = 6;
  // bound on applied vector lines
  localparam int max_lines = 200;

  logic snpcrtclk;
  logic cpurst_b;
  logic ac_req, icc_snq_create_permit, lm_snq_stall;
  logic cur_snq_entry_empty, cur_ctcq_entry_empty;
  logic cr_resp_acept, snq_cr_valid, ctcq_cr_valid, ctcq_2_cmplt;
  logic [pa_width-1:0]   ac_addr;
  logic [snoop_w-1:0]    ac_snoop;
  logic [prot_w-1:0]     ac_prot;
  // dut outputs
  logic ac_ready, snoop_req_create_en, ctc_req_create_en, ctc_2nd_trans;
  logic [pa_width-1:0]   snq_snoop_addr;
  logic [snoop_w-1:0]    snq_snoop_type;
  logic [prot_w-1:0]     snq_snoop_prot;
  logic [ctc_type_w-1:0] ctc_type;
  logic [asid_va_w-1:0]  ctc_asid_va;
  logic [va_pa_w-1:0]    ctc_va_pa;
  logic [idx_depth-1:0]  snq_oldest_index, ctcq_oldest_index;
  // expected values, one set per vector line
  logic exp_ready, exp_snp_create, exp_ctc_create, exp_2nd_trans;
  logic [ctc_type_w-1:0] exp_ctc_type;
  logic [asid_va_w-1:0]  exp_asid_va;
  logic [va_pa_w-1:0]    exp_va_pa;
  logic [idx_depth-1:0]  exp_snq_oldest, exp_ctcq_oldest;
  logic                  check_en;
  logic [8*12-1:0]       test_name;
  logic                  done_reading;
  int                    mismatch_cnt, other_errs, line_cnt, fd, n_fields;
  string                 line;

  snoop_req_arbiter #(.coq_depth(coq_depth), .idx_depth(idx_depth)) u_snoop_req_arbiter (.*);

  snoop_arb_checker #(.idx_depth(idx_depth)) u_snoop_arb_checker (.*);

  // 100 ns clock
  initial
  begin
    snpcrtclk = 1'b0;
    forever #50 snpcrtclk = ~snpcrtclk;
  end

  // ========================================
  // reset, then one vector line per cycle
  // ========================================
  initial
  begin
    {ac_req, icc_snq_create_permit, lm_snq_stall} = '0;
    {cur_snq_entry_empty, cur_ctcq_entry_empty} = '0;
    {cr_resp_acept, snq_cr_valid, ctcq_cr_valid, ctcq_2_cmplt} = '0;
    ac_addr = '0;
    ac_snoop = '0;
    ac_prot = '0;
    cpurst_b = 1'b0;
    check_en = 1'b0;
    test_name = '0;
    done_reading = 1'b0;
    other_errs = 0;
    line_cnt = 0;
    repeat (2) @(posedge snpcrtclk);
    fd = $fopen("tb/snoop_arb_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("error: vector file tb/snoop_arb_vectors.txt could not be opened");
      other_errs++;
      done_reading = 1'b1;
    end
    // release reset on the falling edge, first line goes out with it
    @(negedge snpcrtclk);
    cpurst_b = 1'b1;
    while (!done_reading && line_cnt < max_lines)
    begin
      line = "";
      if ($fgets(line, fd) == 0)
        done_reading = 1'b1;
      else if (line.len() > 1 && line.getc(0) != "#")
      begin
        n_fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          test_name, ac_req, ac_addr, ac_snoop, ac_prot, icc_snq_create_permit, lm_snq_stall,
          cur_snq_entry_empty, cur_ctcq_entry_empty, cr_resp_acept, snq_cr_valid,
          ctcq_cr_valid, ctcq_2_cmplt, exp_ready, exp_snp_create, exp_ctc_create,
          exp_ctc_type, exp_asid_va, exp_2nd_trans, exp_va_pa, exp_snq_oldest, exp_ctcq_oldest);
        if (n_fields != 22)
        begin
          $display("error: vector line could not be read: %s", line);
          other_errs++;
        end
        else
        begin
          check_en = 1'b1;
          line_cnt++;
          // checker compares at the rising edge in between
          @(negedge snpcrtclk);
        end
      end
    end
    check_en = 1'b0;
    if (!done_reading)
    begin
      $display("error: timeout, vector file not finished after %0d lines", max_lines);
      other_errs++;
    end
    if (fd != 0)
      $fclose(fd);
    if (line_cnt == 0)
    begin
      $display("error: no vector line was applied");
      other_errs++;
    end
    $display("vectors %0d, mismatches %0d, other errors %0d", line_cnt, mismatch_cnt, other_errs);
    if (mismatch_cnt == 0 && other_errs == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

//--- tb/snoop_arb_checker.sv
`timescale 1ns/1ps

module snoop_arb_checker
  import snoop_arb_pkg::*;
#(
  parameter int idx_depth = 6
) (
  input  logic                  snpcrtclk,
  input  logic                  check_en,
  input  logic [8*12-1:0]       test_name,
  // ac fields as driven, for the pass-through check
  input  logic [pa_width-1:0]   ac_addr,
  input  logic [snoop_w-1:0]    ac_snoop,
  input  logic [prot_w-1:0]     ac_prot,
  // dut responses
  input  logic                  ac_ready,
  input  logic                  snoop_req_create_en,
  input  logic                  ctc_req_create_en,
  input  logic [pa_width-1:0]   snq_snoop_addr,
  input  logic [snoop_w-1:0]    snq_snoop_type,
  input  logic [prot_w-1:0]     snq_snoop_prot,
  input  logic [ctc_type_w-1:0] ctc_type,
  input  logic [asid_va_w-1:0]  ctc_asid_va,
  input  logic                  ctc_2nd_trans,
  input  logic [va_pa_w-1:0]    ctc_va_pa,
  input  logic [idx_depth-1:0]  snq_oldest_index,
  input  logic [idx_depth-1:0]  ctcq_oldest_index,
  // expected values from the vector line
  input  logic                  exp_ready,
  input  logic                  exp_snp_create,
  input  logic                  exp_ctc_create,
  input  logic [ctc_type_w-1:0] exp_ctc_type,
  input  logic [asid_va_w-1:0]  exp_asid_va,
  input  logic                  exp_2nd_trans,
  input  logic [va_pa_w-1:0]    exp_va_pa,
  input  logic [idx_depth-1:0]  exp_snq_oldest,
  input  logic [idx_depth-1:0]  exp_ctcq_oldest,
  output int                    mismatch_cnt
);

  int err_cnt = 0;

  assign mismatch_cnt = err_cnt;

  // one field, x or z also count as wrong
  task automatic compare_value(input string field, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
    if (exp_val !== act_val)
    begin
      $display("mismatch %0s %0s: expected %0h actual %0h", test_name, field, exp_val, act_val);
      err_cnt++;
    end
  endtask

  // ========================================
  // compare before the edge updates state
  // ========================================
  always @(posedge snpcrtclk)
  begin
    if (check_en)
    begin
      compare_value("ac_ready", exp_ready, ac_ready);
      compare_value("snoop_req_create_en", exp_snp_create, snoop_req_create_en);
      compare_value("ctc_req_create_en", exp_ctc_create, ctc_req_create_en);
      // snq fields pass straight through
      compare_value("snq_snoop_addr", ac_addr, snq_snoop_addr);
      compare_value("snq_snoop_type", ac_snoop, snq_snoop_type);
      compare_value("snq_snoop_prot", ac_prot, snq_snoop_prot);
      // ctcq decode
      compare_value("ctc_type", exp_ctc_type, ctc_type);
      compare_value("ctc_asid_va", exp_asid_va, ctc_asid_va);
      compare_value("ctc_2nd_trans", exp_2nd_trans, ctc_2nd_trans);
      compare_value("ctc_va_pa", exp_va_pa, ctc_va_pa);
      // order tracking
      compare_value("snq_oldest_index", exp_snq_oldest, snq_oldest_index);
      compare_value("ctcq_oldest_index", exp_ctcq_oldest, ctcq_oldest_index);
    end
  end

endmodule

//--- source/snoop_req_arbiter.sv
`timescale 1ns/1ps

module snoop_req_arbiter
  import snoop_arb_pkg::*;
#(
  parameter int coq_depth = 18,
  parameter int idx_depth = 6
) (
  input  logic                  snpcrtclk,
  input  logic                  cpurst_b,
  // ac request channel
  input  logic                  ac_req,
  input  logic [pa_width-1:0]   ac_addr,
  input  logic [snoop_w-1:0]    ac_snoop,
  input  logic [prot_w-1:0]     ac_prot,
  output logic                  ac_ready,
  // queue conditions
  input  logic                  icc_snq_create_permit,
  input  logic                  lm_snq_stall,
  input  logic                  cur_snq_entry_empty,
  input  logic                  cur_ctcq_entry_empty,
  // cr response side
  input  logic                  cr_resp_acept,
  input  logic                  snq_cr_valid,
  input  logic                  ctcq_cr_valid,
  input  logic                  ctcq_2_cmplt,
  // create enables and entry fields
  output logic                  snoop_req_create_en,
  output logic                  ctc_req_create_en,
  output logic [pa_width-1:0]   snq_snoop_addr,
  output logic [snoop_w-1:0]    snq_snoop_type,
  output logic [prot_w-1:0]     snq_snoop_prot,
  output logic [ctc_type_w-1:0] ctc_type,
  output logic [asid_va_w-1:0]  ctc_asid_va,
  output logic                  ctc_2nd_trans,
  output logic [va_pa_w-1:0]    ctc_va_pa,
  // oldest entries for response return
  output logic [idx_depth-1:0]  snq_oldest_index,
  output logic [idx_depth-1:0]  ctcq_oldest_index
);

  ac_addr_u             ac_addr_dec;
  logic [coq_depth-1:0] slot_vld;
  logic [coq_depth-1:0] slot_src;

  assign ac_addr_dec = ac_addr;

  coq_write_if #(.coq_depth(coq_depth)) coq_wr ();

  // ========================================
  // classify and build entry fields
  // ========================================
  ac_classify u_ac_classify (
    .ac_req                (ac_req),
    .ac_addr               (ac_addr_dec),
    .ac_snoop              (ac_snoop),
    .ac_prot               (ac_prot),
    .icc_snq_create_permit (icc_snq_create_permit),
    .lm_snq_stall          (lm_snq_stall),
    .cur_snq_entry_empty   (cur_snq_entry_empty),
    .cur_ctcq_entry_empty  (cur_ctcq_entry_empty),
    .ac_ready              (ac_ready),
    .snoop_req_create_en   (snoop_req_create_en),
    .ctc_req_create_en     (ctc_req_create_en),
    .snq_snoop_addr        (snq_snoop_addr),
    .snq_snoop_type        (snq_snoop_type),
    .snq_snoop_prot        (snq_snoop_prot),
    .ctc_type              (ctc_type),
    .ctc_asid_va           (ctc_asid_va),
    .ctc_2nd_trans         (ctc_2nd_trans),
    .ctc_va_pa             (ctc_va_pa)
  );

  // ========================================
  // create order queue
  // ========================================
  coq_alloc #(.coq_depth(coq_depth), .idx_depth(idx_depth)) u_coq_alloc (
    .snpcrtclk           (snpcrtclk),
    .cpurst_b            (cpurst_b),
    .snoop_req_create_en (snoop_req_create_en),
    .ctc_req_create_en   (ctc_req_create_en),
    .cr_resp_acept       (cr_resp_acept),
    .wr                  (coq_wr.alloc)
  );

  // one slot per create order position
  for (genvar g = 0; g < coq_depth; g++)
  begin : g_slot
    coq_entry #(.coq_depth(coq_depth), .slot_idx(g)) u_coq_entry (
      .snpcrtclk (snpcrtclk),
      .cpurst_b  (cpurst_b),
      .wr        (coq_wr.entry),
      .slot_vld  (slot_vld[g]),
      .slot_src  (slot_src[g])
    );
  end

  // head slot picks snq or ctcq oldest
  resp_order_select #(.coq_depth(coq_depth), .idx_depth(idx_depth)) u_resp_order_select (
    .snpcrtclk         (snpcrtclk),
    .cpurst_b          (cpurst_b),
    .cr_resp_acept     (cr_resp_acept),
    .snq_cr_valid      (snq_cr_valid),
    .ctcq_cr_valid     (ctcq_cr_valid),
    .ctcq_2_cmplt      (ctcq_2_cmplt),
    .pop_ptr           (coq_wr.pop_ptr),
    .slot_vld          (slot_vld),
    .slot_src          (slot_src),
    .snq_oldest_index  (snq_oldest_index),
    .ctcq_oldest_index (ctcq_oldest_index)
  );

endmodule

//--- source/resp_order_select.sv
`timescale 1ns/1ps

module resp_order_select #(
  parameter int coq_depth = 18,
  parameter int idx_depth = 6
) (
  input  logic                          snpcrtclk,
  input  logic                          cpurst_b,
  input  logic                          cr_resp_acept,
  input  logic                          snq_cr_valid,
  input  logic                          ctcq_cr_valid,
  input  logic                          ctcq_2_cmplt,
  input  logic [$clog2(coq_depth)-1:0]  pop_ptr,
  input  logic [coq_depth-1:0]          slot_vld,
  input  logic [coq_depth-1:0]          slot_src,
  output logic [idx_depth-1:0]          snq_oldest_index,
  output logic [idx_depth-1:0]          ctcq_oldest_index
);

  logic [idx_depth-1:0] snq_idx;
  logic [idx_depth-1:0] ctcq_idx;
  logic                 head_vld;
  logic                 head_src;

  // ========================================
  // rotating oldest indexes
  // ========================================
  // snq advances on every snq response
  always_ff @(posedge snpcrtclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      snq_idx <= idx_depth'(1);
    else if (cr_resp_acept && snq_cr_valid)
      snq_idx <= {snq_idx[idx_depth-2:0], snq_idx[idx_depth-1]};
  end

  // ctcq holds while the second transaction is outstanding
  always_ff @(posedge snpcrtclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ctcq_idx <= idx_depth'(1);
    else if (cr_resp_acept && ctcq_cr_valid && !ctcq_2_cmplt)
      ctcq_idx <= {ctcq_idx[idx_depth-2:0], ctcq_idx[idx_depth-1]};
  end

  // ========================================
  // oldest entry for response return
  // ========================================
  // head of the create order queue
  assign head_vld = slot_vld[pop_ptr];
  assign head_src = slot_src[pop_ptr];

  // only the queue that owns the head shows an index
  assign snq_oldest_index  = snq_idx & {idx_depth{head_vld && !head_src}};
  assign ctcq_oldest_index = ctcq_idx & {idx_depth{head_vld && head_src}};

  a_idx_onehot: assert property (@(posedge snpcrtclk) disable iff (!cpurst_b)
    $onehot(snq_idx) && $onehot(ctcq_idx));

endmodule

//--- source/coq_entry.sv
`timescale 1ns/1ps

module coq_entry #(
  parameter int coq_depth = 18,
  parameter int slot_idx  = 0
) (
  input  logic        snpcrtclk,
  input  logic        cpurst_b,
  coq_write_if.entry  wr,
  output logic        slot_vld,
  output logic        slot_src
);

  localparam int ptr_w = $clog2(coq_depth);

  logic hit_create;
  logic hit_pop;

  // this slot addressed by either pointer
  assign hit_create = wr.create_en && (wr.create_ptr == ptr_w'(slot_idx));
  assign hit_pop    = wr.pop_en && (wr.pop_ptr == ptr_w'(slot_idx));

  // ========================================
  // slot state
  // ========================================
  always_ff @(posedge snpcrtclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      slot_vld <= 1'b0;
    else if (hit_create)
      slot_vld <= 1'b1;
    else if (hit_pop)
      slot_vld <= 1'b0;
  end

  // snq or ctcq source of the slot
  always_ff @(posedge snpcrtclk)
  begin
    if (hit_create)
      slot_src <= wr.create_src;
  end

  // create must land in a free slot
  a_no_overflow: assert property (@(posedge snpcrtclk) disable iff (!cpurst_b)
    hit_create |-> !slot_vld);

  // a response must have a recorded create
  a_no_underflow: assert property (@(posedge snpcrtclk) disable iff (!cpurst_b)
    hit_pop |-> slot_vld);

endmodule

//--- source/coq_alloc.sv
`timescale 1ns/1ps

module coq_alloc #(
  parameter int coq_depth = 18,
  parameter int idx_depth = 6
) (
  input  logic        snpcrtclk,
  input  logic        cpurst_b,
  input  logic        snoop_req_create_en,
  input  logic        ctc_req_create_en,
  input  logic        cr_resp_acept,
  coq_write_if.alloc  wr
);

  localparam int ptr_w = $clog2(coq_depth);
  localparam logic [ptr_w-1:0] ptr_max = ptr_w'(coq_depth - 1);

  logic             create_fire;
  logic [ptr_w-1:0] create_ptr;
  logic [ptr_w-1:0] pop_ptr;

  assign create_fire = snoop_req_create_en || ctc_req_create_en;

  // ========================================
  // create pointer
  // ========================================
  always_ff @(posedge snpcrtclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      create_ptr <= '0;
    else if (create_fire)
    begin
      // wrap after last slot
      if (create_ptr == ptr_max)
        create_ptr <= '0;
      else
        create_ptr <= create_ptr + 1'b1;
    end
  end

  // ========================================
  // pop pointer
  // ========================================
  always_ff @(posedge snpcrtclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      pop_ptr <= '0;
    else if (cr_resp_acept)
    begin
      if (pop_ptr == ptr_max)
        pop_ptr <= '0;
      else
        pop_ptr <= pop_ptr + 1'b1;
    end
  end

  // events out to every slot
  assign wr.create_en  = create_fire;
  assign wr.create_src = ctc_req_create_en;
  assign wr.create_ptr = create_ptr;
  assign wr.pop_en     = cr_resp_acept;
  assign wr.pop_ptr    = pop_ptr;

  // room for a full snq plus two transactions per ctcq entry
  a_depth_rule: assert property (@(posedge snpcrtclk)
    coq_depth >= 3 * idx_depth);

  a_ptr_range: assert property (@(posedge snpcrtclk) disable iff (!cpurst_b)
    (create_ptr < coq_depth) && (pop_ptr < coq_depth));

endmodule

//--- source/ac_classify.sv
`timescale 1ns/1ps

module ac_classify
  import snoop_arb_pkg::*;
(
  input  logic                  ac_req,
  input  ac_addr_u              ac_addr,
  input  logic [snoop_w-1:0]    ac_snoop,
  input  logic [prot_w-1:0]     ac_prot,
  input  logic                  icc_snq_create_permit,
  input  logic                  lm_snq_stall,
  input  logic                  cur_snq_entry_empty,
  input  logic                  cur_ctcq_entry_empty,
  output logic                  ac_ready,
  output logic                  snoop_req_create_en,
  output logic                  ctc_req_create_en,
  output logic [pa_width-1:0]   snq_snoop_addr,
  output logic [snoop_w-1:0]    snq_snoop_type,
  output logic [prot_w-1:0]     snq_snoop_prot,
  output logic [ctc_type_w-1:0] ctc_type,
  output logic [asid_va_w-1:0]  ctc_asid_va,
  output logic                  ctc_2nd_trans,
  output logic [va_pa_w-1:0]    ctc_va_pa
);

  logic snp_req;
  logic ctc_req;
  logic dest_empty;

  // ========================================
  // request split into snoop or ctc
  // ========================================
  // all ones snoop code goes to ctcq
  assign ctc_req = ac_req && (ac_snoop == ctc_snoop_code);
  assign snp_req = ac_req && !ctc_req;

  // empty flag of the queue this request targets
  assign dest_empty = (snp_req && cur_snq_entry_empty)
                   || (ctc_req && cur_ctcq_entry_empty);

  // stall and permit hold off both queues alike
  assign ac_ready = dest_empty
                 && !lm_snq_stall
                 && icc_snq_create_permit;

  // create only on the handshake cycle
  assign snoop_req_create_en = snp_req && ac_ready;
  assign ctc_req_create_en   = ctc_req && ac_ready;

  // ========================================
  // snq entry fields
  // ========================================
  // straight from the ac channel
  assign snq_snoop_addr = ac_addr;
  assign snq_snoop_type = ac_snoop;
  assign snq_snoop_prot = ac_prot;

  // ========================================
  // ctcq entry fields
  // ========================================
  // type bits 14:12, 6:5 and 0 of first transaction
  assign ctc_type = {ac_addr.first_tr.type_hi,
                     ac_addr.first_tr.type_mid,
                     ac_addr.first_tr.second_trans};

  // asid for tlbi, va for ici
  assign ctc_asid_va = ac_addr.first_tr.asid_va;

  // second transaction still to come
  assign ctc_2nd_trans = ac_addr.first_tr.second_trans;

  // va for tlbi or pa for ici from the second transaction
  assign ctc_va_pa = ac_addr.second_tr.va_pa;

endmodule

//--- source/coq_write_if.sv
`timescale 1ns/1ps

interface coq_write_if #(
  parameter int coq_depth = 18
);

  localparam int ptr_w = $clog2(coq_depth);

  // create side, one slot per accepted ac request
  logic             create_en;
  // 0 for snq, 1 for ctcq
  logic             create_src;
  logic [ptr_w-1:0] create_ptr;

  // pop side, one slot per accepted cr response
  logic             pop_en;
  logic [ptr_w-1:0] pop_ptr;

  modport alloc (
    output create_en, create_src, create_ptr, pop_en, pop_ptr
  );

  modport entry (
    input create_en, create_src, create_ptr, pop_en, pop_ptr
  );

endinterface

//--- source/snoop_arb_pkg.sv
package snoop_arb_pkg;

  // ========================================
  // ac channel field widths
  // ========================================
  parameter int pa_width   = 40;
  parameter int snoop_w    = 4;
  parameter int prot_w     = 3;

  // ctcq entry field widths
  parameter int ctc_type_w = 6;
  parameter int asid_va_w  = 24;
  parameter int va_pa_w    = 36;

  // snoop code reserved for cache/tlb maintenance
  parameter logic [snoop_w-1:0] ctc_snoop_code = 4'b1111;

  // ========================================
  // ac address word, two decodes
  // ========================================
  // first_tr is the first transaction of a ctc request
  // second_tr only follows when first_tr.second_trans is set
  typedef union packed {
    struct packed {
      logic [asid_va_w-1:0] asid_va;
      logic                 rsvd_15;
      logic [2:0]           type_hi;
      logic [4:0]           rsvd_11_7;
      logic [1:0]           type_mid;
      logic [3:0]           rsvd_4_1;
      logic                 second_trans;
    } first_tr;
    struct packed {
      logic [va_pa_w-1:0]   va_pa;
      logic [3:0]           rsvd_3_0;
    } second_tr;
  } ac_addr_u;

endpackage
